// File: hdl/booth_mul_defs.svh
//--------------------
// Operand width, partial-product row count
// and compressor tree split for the multiplier
//--------------------
`ifndef BOOTH_MUL_DEFS_SVH
`define BOOTH_MUL_DEFS_SVH

`define MUL_W 64

// One row per Booth digit plus the gathered negation row
`define PP_ROWS (`MUL_W / 2 + 2)

`define FRONT_LEVELS 2
`define BACK_LEVELS 3

`endif

// File: hdl/booth_mul_pkg.sv
//--------------------
// Multiplier vector types and the
// carry-save row count helper
//--------------------
`include "booth_mul_defs.svh"

package booth_mul_pkg;

    typedef logic [`MUL_W-1:0]   operand_t;
    typedef logic [`MUL_W:0]     operand_ext_t;
    typedef logic [2*`MUL_W-1:0] prod_t;

    // Bit 1 marks operand a signed, bit 0 marks operand b signed
    typedef logic [1:0]          sign_mode_t;
    typedef logic [2:0]          booth_digit_t;

    // Rows left after a number of 4:2 levels, leftover three goes 3:2
    function automatic int csa_rows_after(input int rows_in, input int levels);
        int rows;
        int rem;
        rows = rows_in;
        for (int l = 0; l < levels; l++) begin
            rem = rows % 4;
            rows = (rows / 4) * 2 + ((rem == 3) ? 2 : rem);
        end
        return rows;
    endfunction

endpackage

// File: hdl/booth_pp_gen.sv
//--------------------
// Radix-4 Booth recoder and
// partial-product row generator
//--------------------
`timescale 1ns/1ps
`include "booth_mul_defs.svh"

module booth_pp_gen (
    input  booth_mul_pkg::sign_mode_t mul_signed_i,
    input  booth_mul_pkg::operand_t   mul_a_i,
    input  booth_mul_pkg::operand_t   mul_b_i,
    output booth_mul_pkg::prod_t      pp_rows_o [`PP_ROWS]
);

    localparam int DIGITS = `PP_ROWS - 1;

    booth_mul_pkg::operand_ext_t a_ext;
    booth_mul_pkg::operand_ext_t b_ext;
    logic [`MUL_W+2:0]           b_pad;
    logic [DIGITS-1:0]           neg_bits;
    booth_mul_pkg::prod_t        neg_row;
    logic [`MUL_W+1:0]           a_x1;
    logic [`MUL_W+1:0]           a_x2;

    // One extra bit so an unsigned operand reads as a positive signed value
    assign a_ext = mul_signed_i[1] ? {mul_a_i[`MUL_W-1], mul_a_i} : {1'b0, mul_a_i};
    assign b_ext = mul_signed_i[0] ? {mul_b_i[`MUL_W-1], mul_b_i} : {1'b0, mul_b_i};

    // Zero below bit 0, sign repeated above the top for the last triple
    assign b_pad = {b_ext[`MUL_W], b_ext, 1'b0};

    assign a_x1 = {a_ext[`MUL_W], a_ext};
    assign a_x2 = {a_ext, 1'b0};

    for (genvar i = 0; i < DIGITS; i++) begin : g_digit
        booth_mul_pkg::booth_digit_t trip;
        logic                        neg;
        logic [`MUL_W+1:0]           mag;
        logic [`MUL_W+1:0]           sel;

        assign trip = b_pad[2*i +: 3];

        always_comb begin
            unique case (trip)
                3'b001, 3'b010: begin
                    mag = a_x1;
                    neg = 1'b0;
                end
                3'b011: begin
                    mag = a_x2;
                    neg = 1'b0;
                end
                3'b100: begin
                    mag = a_x2;
                    neg = 1'b1;
                end
                3'b101, 3'b110: begin
                    mag = a_x1;
                    neg = 1'b1;
                end
                default: begin
                    mag = '0;
                    neg = 1'b0;
                end
            endcase
        end

        // Ones' complement here, the +1 lands in the negation row
        assign sel = neg ? ~mag : mag;
        assign neg_bits[i] = neg;
        assign pp_rows_o[i] = {{(`MUL_W-2){sel[`MUL_W+1]}}, sel} << (2 * i);
    end

    always_comb begin
        neg_row = '0;
        for (int i = 0; i < DIGITS; i++) begin
            neg_row[2*i] = neg_bits[i];
        end
    end

    assign pp_rows_o[`PP_ROWS-1] = neg_row;

endmodule

// File: hdl/compressor_42.sv
//--------------------
// Bit-parallel 4:2 carry-save compressor
//--------------------
`timescale 1ns/1ps

module compressor_42 #(
    parameter int WIDTH = 128
) (
    input  logic [WIDTH-1:0] data0_i,
    input  logic [WIDTH-1:0] data1_i,
    input  logic [WIDTH-1:0] data2_i,
    input  logic [WIDTH-1:0] data3_i,
    output logic [WIDTH-1:0] sum_o,
    output logic [WIDTH-1:0] carry_o
);

    logic [WIDTH-1:0] s1;
    logic [WIDTH-1:0] c1;
    logic [WIDTH-1:0] c1_sh;
    logic [WIDTH-1:0] c2;

    // First full-adder row over three inputs
    assign s1 = data0_i ^ data1_i ^ data2_i;
    assign c1 = (data0_i & data1_i) | (data0_i & data2_i) | (data1_i & data2_i);
    assign c1_sh = {c1[WIDTH-2:0], 1'b0};

    // Second row folds in the fourth input and the first carry
    assign sum_o = s1 ^ data3_i ^ c1_sh;
    assign c2 = (s1 & data3_i) | (s1 & c1_sh) | (data3_i & c1_sh);

    // Top carry bit falls off, arithmetic is modulo 2^WIDTH
    assign carry_o = {c2[WIDTH-2:0], 1'b0};

endmodule

// File: hdl/csa_tree.sv
//--------------------
// Generic carry-save reduction tree
// built from 4:2 groups per level
//--------------------
`timescale 1ns/1ps

module csa_tree #(
    parameter int ROWS_IN = 34,
    parameter int LEVELS  = 2
) (
    input  booth_mul_pkg::prod_t rows_i [ROWS_IN],
    output booth_mul_pkg::prod_t rows_o [booth_mul_pkg::csa_rows_after(ROWS_IN, LEVELS)]
);

    localparam int PW = $bits(booth_mul_pkg::prod_t);

    if (LEVELS == 0) begin : g_bypass
        assign rows_o = rows_i;
    end else begin : g_reduce
        for (genvar l = 0; l < LEVELS; l++) begin : g_level
            localparam int N_IN   = booth_mul_pkg::csa_rows_after(ROWS_IN, l);
            localparam int N_OUT  = booth_mul_pkg::csa_rows_after(ROWS_IN, l + 1);
            localparam int GROUPS = N_IN / 4;
            localparam int REM    = N_IN % 4;

            booth_mul_pkg::prod_t rin  [N_IN];
            booth_mul_pkg::prod_t rout [N_OUT];

            if (l == 0) begin : g_src
                assign rin = rows_i;
            end else begin : g_src
                assign rin = g_level[l-1].rout;
            end

            // Every full group of four becomes a sum and a carry row
            for (genvar g = 0; g < GROUPS; g++) begin : g_c42
                compressor_42 #(
                    .WIDTH (PW)
                ) u_c42 (
                    .data0_i (rin[4*g]),
                    .data1_i (rin[4*g+1]),
                    .data2_i (rin[4*g+2]),
                    .data3_i (rin[4*g+3]),
                    .sum_o   (rout[2*g]),
                    .carry_o (rout[2*g+1])
                );
            end

            if (REM == 3) begin : g_c32
                booth_mul_pkg::prod_t maj;

                // Single full-adder row for the three leftovers
                assign rout[2*GROUPS] = rin[4*GROUPS] ^ rin[4*GROUPS+1] ^ rin[4*GROUPS+2];
                assign maj = (rin[4*GROUPS] & rin[4*GROUPS+1])
                           | (rin[4*GROUPS] & rin[4*GROUPS+2])
                           | (rin[4*GROUPS+1] & rin[4*GROUPS+2]);
                assign rout[2*GROUPS+1] = {maj[PW-2:0], 1'b0};
            end else begin : g_pass
                // One or two rows wait for the next level
                for (genvar p = 0; p < REM; p++) begin : g_row
                    assign rout[2*GROUPS+p] = rin[4*GROUPS+p];
                end
            end
        end

        assign rows_o = g_level[LEVELS-1].rout;
    end

endmodule

// File: hdl/booth_mul.sv
//--------------------
// Pipelined 64x64 Booth multiplier top
// Two register stages with valid/ready flow
// control, final carry-propagate adder
//--------------------
`timescale 1ns/1ps
`include "booth_mul_defs.svh"

module booth_mul (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       mul_flush_i,
    input  logic                       mul_valid_i,
    output logic                       mul_ready_o,
    input  booth_mul_pkg::sign_mode_t  mul_signed_i,
    input  booth_mul_pkg::operand_t    mul_a_i,
    input  booth_mul_pkg::operand_t    mul_b_i,
    output booth_mul_pkg::operand_t    mul_result_hi_o,
    output booth_mul_pkg::operand_t    mul_result_lo_o,
    output logic                       mul_out_valid_o,
    input  logic                       mul_out_ready_i
);

    localparam int FRONT_ROWS = booth_mul_pkg::csa_rows_after(`PP_ROWS, `FRONT_LEVELS);
    localparam int BACK_ROWS  = booth_mul_pkg::csa_rows_after(FRONT_ROWS, `BACK_LEVELS);

    booth_mul_pkg::prod_t pp_rows    [`PP_ROWS];
    booth_mul_pkg::prod_t front_rows [FRONT_ROWS];
    booth_mul_pkg::prod_t s1_rows_q  [FRONT_ROWS];
    booth_mul_pkg::prod_t back_rows  [BACK_ROWS];
    booth_mul_pkg::prod_t s2_rows_q  [BACK_ROWS];
    booth_mul_pkg::prod_t result;

    logic s1_valid_q;
    logic s2_valid_q;
    logic advance;

    booth_pp_gen u_pp_gen (
        .mul_signed_i (mul_signed_i),
        .mul_a_i      (mul_a_i),
        .mul_b_i      (mul_b_i),
        .pp_rows_o    (pp_rows)
    );

    csa_tree #(
        .ROWS_IN (`PP_ROWS),
        .LEVELS  (`FRONT_LEVELS)
    ) u_tree_front (
        .rows_i (pp_rows),
        .rows_o (front_rows)
    );

    csa_tree #(
        .ROWS_IN (FRONT_ROWS),
        .LEVELS  (`BACK_LEVELS)
    ) u_tree_back (
        .rows_i (s1_rows_q),
        .rows_o (back_rows)
    );

    // Whole pipeline moves when the output slot is free or being taken
    assign advance = !s2_valid_q || mul_out_ready_i;
    assign mul_ready_o = advance;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (mul_flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (advance) begin
            s1_valid_q <= mul_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && mul_valid_i) begin
            s1_rows_q <= front_rows;
        end
        if (advance && s1_valid_q) begin
            s2_rows_q <= back_rows;
        end
    end

    // Carry-propagate add of the last sum and carry rows
    assign result = s2_rows_q[0] + s2_rows_q[1];

    assign mul_result_hi_o = result[2*`MUL_W-1:`MUL_W];
    assign mul_result_lo_o = result[`MUL_W-1:0];
    assign mul_out_valid_o = s2_valid_q;

    // A stalled result must not change until the consumer takes it
    a_out_hold: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (mul_out_valid_o && !mul_out_ready_i && !mul_flush_i)
        |=> (mul_out_valid_o && $stable(mul_result_hi_o) && $stable(mul_result_lo_o))
    );

    // Work waiting in stage 1 survives a stall
    a_stage1_hold: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (s1_valid_q && !advance && !mul_flush_i) |=> s1_valid_q
    );

endmodule

// File: bench/tb_booth_mul.sv
//--------------------
// Testbench for the Booth multiplier
// File vectors, random and stalled traffic,
// flush, scoreboard and watchdog
//--------------------
`timescale 1ns/1ps

module tb_booth_mul;

    localparam int RESET_CYCLES  = 16;
    localparam int MAX_VECS      = 32;
    localparam int RAND_OPS      = 300;
    localparam int STALL_OPS     = 200;
    localparam int CYCLES_PER_OP = 8;

    logic                      clk = 1'b0;
    logic                      arst_n_i;
    logic                      mul_flush_i;
    logic                      mul_valid_i;
    logic                      mul_ready_o;
    booth_mul_pkg::sign_mode_t mul_signed_i;
    booth_mul_pkg::operand_t   mul_a_i;
    booth_mul_pkg::operand_t   mul_b_i;
    booth_mul_pkg::operand_t   mul_result_hi_o;
    booth_mul_pkg::operand_t   mul_result_lo_o;
    logic                      mul_out_valid_o;
    logic                      mul_out_ready_i;

    logic [63:0]          vec_mem [5*MAX_VECS+1];
    booth_mul_pkg::prod_t exp_q [$];
    string                name_q [$];
    booth_mul_pkg::prod_t cur_exp;
    string                cur_name;
    booth_mul_pkg::prod_t out_val;
    booth_mul_pkg::prod_t held_val;
    logic                 held = 1'b0;
    logic                 out_stalled;
    logic                 stall_en = 1'b0;
    logic                 loaded = 1'b0;
    logic [63:0]          op_rng;
    logic [63:0]          stall_rng;
    int                   n_vecs = 0;
    int                   checks = 0;
    int                   errors = 0;

    booth_mul uut (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .mul_flush_i     (mul_flush_i),
        .mul_valid_i     (mul_valid_i),
        .mul_ready_o     (mul_ready_o),
        .mul_signed_i    (mul_signed_i),
        .mul_a_i         (mul_a_i),
        .mul_b_i         (mul_b_i),
        .mul_result_hi_o (mul_result_hi_o),
        .mul_result_lo_o (mul_result_lo_o),
        .mul_out_valid_o (mul_out_valid_o),
        .mul_out_ready_i (mul_out_ready_i)
    );

    assign out_val = {mul_result_hi_o, mul_result_lo_o};

    always #50 clk = ~clk;

    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // Full 128-bit product, each operand extended as its mode bit says
    function automatic booth_mul_pkg::prod_t model_product(
        input booth_mul_pkg::sign_mode_t mode,
        input booth_mul_pkg::operand_t   a,
        input booth_mul_pkg::operand_t   b
    );
        booth_mul_pkg::prod_t wa;
        booth_mul_pkg::prod_t wb;
        wa = {{64{mode[1] & a[63]}}, a};
        wb = {{64{mode[0] & b[63]}}, b};
        return wa * wb;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
        if (stall_en) begin
            stall_rng = xorshift64(stall_rng);
            mul_out_ready_i = stall_rng[40];
        end
    endtask

    // Holds the operation on the inputs until the DUT takes it
    task automatic issue_op(
        input booth_mul_pkg::sign_mode_t mode,
        input booth_mul_pkg::operand_t   a,
        input booth_mul_pkg::operand_t   b,
        input booth_mul_pkg::prod_t      expected,
        input string                     name
    );
        mul_valid_i = 1'b1;
        mul_signed_i = mode;
        mul_a_i = a;
        mul_b_i = b;
        cur_exp = expected;
        cur_name = name;
        @(negedge clk);
        while (!mul_ready_o) begin
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        mul_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int budget;
        budget = CYCLES_PER_OP * (exp_q.size() + 1);
        while (exp_q.size() != 0 && budget > 0) begin
            next_cycle();
            budget--;
        end
        if (exp_q.size() != 0) begin
            errors += exp_q.size();
            $display("%0d results never came out of the pipeline", exp_q.size());
            exp_q.delete();
            name_q.delete();
        end
    endtask

    // Scoreboard at mid-cycle, where inputs and outputs are settled
    always @(negedge clk) begin
        if (arst_n_i) begin
            // Ready drops only while a result waits for the consumer
            out_stalled = mul_out_valid_o && !mul_out_ready_i;
            if (mul_ready_o !== !out_stalled) begin
                errors++;
                $display("[ERROR] ready expected %b actual %b", !out_stalled, mul_ready_o);
            end
            if (held && (!mul_out_valid_o || out_val !== held_val)) begin
                errors++;
                $display("[ERROR] stall hold expected %h actual %h", held_val, out_val);
            end
            held = mul_out_valid_o && !mul_out_ready_i && !mul_flush_i;
            held_val = out_val;
            if (mul_flush_i) begin
                exp_q.delete();
                name_q.delete();
            end else begin
                if (mul_out_valid_o && mul_out_ready_i) begin
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("Extra result %h with no operation in flight", out_val);
                    end else begin
                        checks++;
                        if (out_val !== exp_q[0]) begin
                            errors++;
                            $display("[ERROR] %s expected %h actual %h",
                                     name_q[0], exp_q[0], out_val);
                        end
                        void'(exp_q.pop_front());
                        void'(name_q.pop_front());
                    end
                end
                if (mul_valid_i && mul_ready_o) begin
                    exp_q.push_back(cur_exp);
                    name_q.push_back(cur_name);
                end
            end
        end
    end

    initial begin
        booth_mul_pkg::sign_mode_t mode;
        booth_mul_pkg::operand_t   a;
        booth_mul_pkg::operand_t   b;
        arst_n_i = 1'b0;
        mul_flush_i = 1'b0;
        mul_valid_i = 1'b0;
        mul_signed_i = '0;
        mul_a_i = '0;
        mul_b_i = '0;
        mul_out_ready_i = 1'b1;
        cur_exp = '0;
        cur_name = "";
        op_rng = 64'd56200;
        stall_rng = xorshift64(op_rng ^ 64'h5A5A);
        $readmemh("bench/booth_mul_vectors.txt", vec_mem);
        n_vecs = int'(vec_mem[0]);
        if (n_vecs == 0 || n_vecs > MAX_VECS) begin
            errors++;
            $display("Vector file is missing or holds a bad count");
            n_vecs = 0;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        arst_n_i = 1'b1;
        @(negedge clk);
        checks++;
        if (mul_out_valid_o !== 1'b0 || mul_ready_o !== 1'b1) begin
            errors++;
            $display("[ERROR] reset expected valid 0 ready 1 actual valid %b ready %b",
                     mul_out_valid_o, mul_ready_o);
        end
        next_cycle();
        for (int k = 0; k < n_vecs; k++) begin
            issue_op(vec_mem[5*k+1][1:0], vec_mem[5*k+2], vec_mem[5*k+3],
                     {vec_mem[5*k+4], vec_mem[5*k+5]}, $sformatf("vector %0d", k));
        end
        wait_drain();
        // Back to back first, then against a randomly stalling consumer
        for (int k = 0; k < RAND_OPS + STALL_OPS; k++) begin
            stall_en = (k >= RAND_OPS);
            op_rng = xorshift64(op_rng);
            mode = op_rng[1:0];
            op_rng = xorshift64(op_rng);
            a = op_rng;
            op_rng = xorshift64(op_rng);
            b = op_rng;
            issue_op(mode, a, b, model_product(mode, a, b), $sformatf("random %0d", k));
        end
        wait_drain();
        stall_en = 1'b0;
        // Fill both stages behind a blocked output, then flush them away
        mul_out_ready_i = 1'b0;
        issue_op(2'b00, 64'd3, 64'd5, 128'd15, "flush 0");
        issue_op(2'b00, 64'd7, 64'd9, 128'd63, "flush 1");
        mul_flush_i = 1'b1;
        next_cycle();
        mul_flush_i = 1'b0;
        mul_out_ready_i = 1'b1;
        repeat (4) next_cycle();
        issue_op(2'b11, 64'hFFFF_FFFF_FFFF_FFF9, 64'd6,
                 {64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFD6}, "after flush");
        wait_drain();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (n_vecs + RAND_OPS + STALL_OPS + 3) * CYCLES_PER_OP + RESET_CYCLES;
        #(limit * 100);
        $display("Timeout after %0d cycles, the run did not complete", limit);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: booth_mul.f
+incdir+hdl
hdl/booth_mul_pkg.sv
hdl/booth_pp_gen.sv
hdl/compressor_42.sv
hdl/csa_tree.sv
hdl/booth_mul.sv
bench/tb_booth_mul.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the multiplier testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f booth_mul.f --top-module tb_booth_mul -o tb_booth_mul \
    && ./obj_dir/tb_booth_mul > sim.log 2>&1 \
    || { echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: bench/booth_mul_vectors.txt
// Columns: mode a b expected_hi expected_lo, all hex
// Mode bit 1 marks a signed, bit 0 marks b signed
// First word is the vector count in hex
14
0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
0 0000000000000001 0000000000000001 0000000000000000 0000000000000001
0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE 0000000000000001
0 8000000000000000 8000000000000000 4000000000000000 0000000000000000
0 0000000100000000 0000010000000000 0000000000000100 0000000000000000
0 0000000000000001 FFFFFFFFFFFFFFFF 0000000000000000 FFFFFFFFFFFFFFFF
0 0000000100000001 0000000100000001 0000000000000001 0000000200000001
0 00000000FFFFFFFF 00000000FFFFFFFF 0000000000000000 FFFFFFFE00000001
// Both operands signed
3 8000000000000000 8000000000000000 4000000000000000 0000000000000000
3 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000 8000000000000000
3 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000000 0000000000000001
3 FFFFFFFFFFFFFFFF 0000000000000001 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
3 7FFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF 3FFFFFFFFFFFFFFF 0000000000000001
3 FFFFFFFFFFFFFFFE 0000000000000003 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFA
// Mixed modes
2 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000001
1 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000001
2 8000000000000000 0000000000000002 FFFFFFFFFFFFFFFF 0000000000000000
1 8000000000000000 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 8000000000000000
2 0000000000000001 8000000000000000 0000000000000000 8000000000000000
1 0000000000000003 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFA
